/* decode_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          insn_valid_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  insn_word_i,
    output logic                               dec_valid_o,
    output rv_isa_pkg::op_e                    dec_op_o,
    output logic [4:0]                         dec_rd_o,
    output logic [4:0]                         dec_rs1_o,
    output logic [4:0]                         dec_rs2_o,
    output logic [mem_map_pkg::XLEN-1:0]       dec_imm_o,
    output logic [2:0]                         dec_width_o,
    output logic                               halted_o
);

    rv_isa_pkg::insn_u insn_q;

    always_ff @(posedge clk) begin
        if (insn_valid_i) begin
            insn_q <= insn_word_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid_o <= 1'b0;
            halted_o    <= 1'b0;
        end else begin
            dec_valid_o <= insn_valid_i;
            // Sticky until reset
            if (dec_valid_o && dec_op_o == rv_isa_pkg::OP_HALT) begin
                halted_o <= 1'b1;
            end
        end
    end

    // Field extraction, view chosen by opcode
    always_comb begin
        dec_op_o    = rv_isa_pkg::OP_NONE;
        dec_rd_o    = insn_q.i.rd;
        dec_rs1_o   = insn_q.i.rs1;
        dec_rs2_o   = insn_q.s.rs2;
        dec_width_o = insn_q.i.funct3;
        dec_imm_o   = {{20{insn_q.i.imm[11]}}, insn_q.i.imm};
        case (insn_q.i.opcode)
            rv_isa_pkg::OPC_OPIMM: begin
                if (insn_q.i.funct3 == rv_isa_pkg::F3_ADDI) begin
                    dec_op_o = rv_isa_pkg::OP_ADDI;
                end
            end
            rv_isa_pkg::OPC_LOAD: begin
                if (insn_q.i.funct3 == rv_isa_pkg::F3_WORD ||
                    insn_q.i.funct3 == rv_isa_pkg::F3_BYTEU) begin
                    dec_op_o = rv_isa_pkg::OP_LOAD;
                end
            end
            rv_isa_pkg::OPC_STORE: begin
                // Store immediate rebuilt from the split fields
                dec_rd_o    = '0;
                dec_width_o = insn_q.s.funct3;
                dec_imm_o   = {{20{insn_q.s.imm_hi[6]}}, insn_q.s.imm_hi, insn_q.s.imm_lo};
                if (insn_q.s.funct3 == rv_isa_pkg::F3_BYTE ||
                    insn_q.s.funct3 == rv_isa_pkg::F3_WORD) begin
                    dec_op_o = rv_isa_pkg::OP_STORE;
                end
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                // ECALL only, EBREAK and CSRs fall to OP_NONE
                if (insn_q.i.funct3 == 3'b000 && insn_q.i.imm == 12'h000) begin
                    dec_op_o = rv_isa_pkg::OP_HALT;
                end
            end
            default: dec_op_o = rv_isa_pkg::OP_NONE;
        endcase
    end

endmodule : decode_unit

`default_nettype wire

/* dualport_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module dualport_mem (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          imem_req_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  imem_addr_i,
    output logic                               imem_ack_o,
    output logic [mem_map_pkg::XLEN-1:0]       imem_rdata_o,
    input  wire logic                          dmem_cyc_i,
    input  wire logic                          dmem_sel_i,
    input  wire logic                          dmem_wen_i,
    input  wire logic [3:0]                    dmem_byte_en_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  dmem_addr_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  dmem_wdata_i,
    output logic                               dmem_ack_o,
    output logic [mem_map_pkg::XLEN-1:0]       dmem_rdata_o
);

    // Single word array behind both ports
    logic [mem_map_pkg::XLEN-1:0] mem [mem_map_pkg::IDMEM_SIZE];

    logic                                 ireq_ff;
    logic [mem_map_pkg::MEM_ADDR_WIDTH-1:0] iaddr_ff;

    logic                                 dsel_ff;
    logic                                 dwen_ff;
    logic [3:0]                           dbe_ff;
    logic [mem_map_pkg::MEM_ADDR_WIDTH-1:0] daddr_ff;
    logic [mem_map_pkg::XLEN-1:0]         dwdata_ff;

    // Instruction request sampled mid-cycle
    // Byte address reduced to word index
    always_ff @(negedge clk) begin
        if (!rst_n) begin
            ireq_ff <= 1'b0;
        end else begin
            ireq_ff <= imem_req_i;
        end
        iaddr_ff <= imem_addr_i[mem_map_pkg::MEM_ADDR_WIDTH+1:2];
    end

    // Ack follows the held request, data from the sampled index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            imem_ack_o   <= 1'b0;
            imem_rdata_o <= mem_map_pkg::NOP_INSN;
        end else begin
            imem_ack_o <= ireq_ff;
            if (ireq_ff) begin
                imem_rdata_o <= mem[iaddr_ff];
            end
        end
    end

    // Data side, cycle qualified by the address select
    always_ff @(negedge clk) begin
        if (!rst_n) begin
            dsel_ff <= 1'b0;
            dwen_ff <= 1'b0;
        end else begin
            dsel_ff <= dmem_cyc_i & dmem_sel_i;
            dwen_ff <= dmem_wen_i;
        end
        dbe_ff    <= dmem_byte_en_i;
        daddr_ff  <= dmem_addr_i[mem_map_pkg::MEM_ADDR_WIDTH+1:2];
        dwdata_ff <= dmem_wdata_i;
    end

    // Writes merge enabled lanes, no ack
    // Reads give a one-cycle ack even if cyc stays high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem_ack_o <= 1'b0;
        end else begin
            dmem_ack_o <= 1'b0;
            if (dsel_ff && !dmem_ack_o) begin
                if (dwen_ff) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dbe_ff[b]) begin
                            mem[daddr_ff][8*b +: 8] <= dwdata_ff[8*b +: 8];
                        end
                    end
                end else begin
                    dmem_ack_o   <= 1'b1;
                    dmem_rdata_o <= mem[daddr_ff];
                end
            end
        end
    end

endmodule : dualport_mem

`default_nettype wire

/* execute_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          run_i,
    input  wire logic                          load_we_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  load_addr_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  load_data_i,
    input  wire logic                          dec_valid_i,
    input  wire rv_isa_pkg::op_e               dec_op_i,
    input  wire logic [4:0]                    dec_rd_i,
    input  wire logic [4:0]                    dec_rs1_i,
    input  wire logic [4:0]                    dec_rs2_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  dec_imm_i,
    input  wire logic [2:0]                    dec_width_i,
    output logic [4:0]                         rs1_idx_o,
    output logic [4:0]                         rs2_idx_o,
    input  wire logic [mem_map_pkg::XLEN-1:0]  rs1_data_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  rs2_data_i,
    output logic                               dmem_cyc_o,
    output logic                               dmem_sel_o,
    output logic                               dmem_wen_o,
    output logic [3:0]                         dmem_byte_en_o,
    output logic [mem_map_pkg::XLEN-1:0]       dmem_addr_o,
    output logic [mem_map_pkg::XLEN-1:0]       dmem_wdata_o,
    input  wire logic                          dmem_ack_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  dmem_rdata_i,
    output logic                               ex_valid_o,
    output rv_isa_pkg::op_e                    ex_op_o,
    output logic [4:0]                         ex_rd_o,
    output logic [mem_map_pkg::XLEN-1:0]       ex_value_o,
    output logic [1:0]                         ex_byte_off_o,
    output logic [2:0]                         ex_width_o
);

    logic [mem_map_pkg::XLEN-1:0] sum;
    logic [3:0]                   st_be;
    logic [mem_map_pkg::XLEN-1:0] st_wdata;

    // Core-side bus state
    logic                         cpu_cyc;
    logic                         cpu_wen;
    logic [3:0]                   cpu_be;
    logic [mem_map_pkg::XLEN-1:0] cpu_addr;
    logic [mem_map_pkg::XLEN-1:0] cpu_wdata;

    assign rs1_idx_o = dec_rs1_i;
    assign rs2_idx_o = dec_rs2_i;

    // ADDI sum and load/store address alike
    assign sum = rs1_data_i + dec_imm_i;

    // SB puts the byte on every lane, one enable picks it
    always_comb begin
        if (dec_width_i == rv_isa_pkg::F3_BYTE) begin
            st_be    = 4'b0001 << sum[1:0];
            st_wdata = {4{rs2_data_i[7:0]}};
        end else begin
            st_be    = 4'b1111;
            st_wdata = rs2_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_cyc    <= 1'b0;
            cpu_wen    <= 1'b0;
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= 1'b0;
            if (cpu_cyc) begin
                // Store done after one cycle, load waits for ack
                if (cpu_wen) begin
                    cpu_cyc    <= 1'b0;
                    ex_valid_o <= 1'b1;
                end else if (dmem_ack_i) begin
                    cpu_cyc    <= 1'b0;
                    ex_valid_o <= 1'b1;
                    ex_value_o <= dmem_rdata_i;
                end
            end else if (dec_valid_i) begin
                ex_op_o       <= dec_op_i;
                ex_rd_o       <= dec_rd_i;
                ex_width_o    <= dec_width_i;
                ex_byte_off_o <= sum[1:0];
                ex_value_o    <= sum;
                cpu_addr      <= sum;
                case (dec_op_i)
                    rv_isa_pkg::OP_LOAD: begin
                        cpu_cyc <= 1'b1;
                        cpu_wen <= 1'b0;
                        cpu_be  <= 4'b1111;
                    end
                    rv_isa_pkg::OP_STORE: begin
                        cpu_cyc   <= 1'b1;
                        cpu_wen   <= 1'b1;
                        cpu_be    <= st_be;
                        cpu_wdata <= st_wdata;
                    end
                    // ADDI, ECALL and unknown retire at once
                    default: ex_valid_o <= 1'b1;
                endcase
            end
        end
    end

    // Loader owns the data port while stopped
    assign dmem_cyc_o     = run_i ? cpu_cyc   : load_we_i;
    assign dmem_wen_o     = run_i ? cpu_wen   : 1'b1;
    assign dmem_byte_en_o = run_i ? cpu_be    : 4'b1111;
    assign dmem_addr_o    = run_i ? cpu_addr  : load_addr_i;
    assign dmem_wdata_o   = run_i ? cpu_wdata : load_data_i;

    // Only the memory window decodes, anything above is unmapped
    assign dmem_sel_o = (dmem_addr_o[mem_map_pkg::XLEN-1:mem_map_pkg::MEM_ADDR_WIDTH+2] == '0);

endmodule : execute_unit

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          run_i,
    input  wire logic                          retire_i,
    input  wire logic                          halted_i,
    output logic                               imem_req_o,
    output logic [mem_map_pkg::XLEN-1:0]       imem_addr_o,
    input  wire logic                          imem_ack_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  imem_rdata_i,
    output logic                               insn_valid_o,
    output logic [mem_map_pkg::XLEN-1:0]       insn_word_o
);

    logic [mem_map_pkg::XLEN-1:0] pc;
    // Instruction in flight downstream
    logic busy;

    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc           <= '0;
            busy         <= 1'b0;
            imem_req_o   <= 1'b0;
            insn_valid_o <= 1'b0;
        end else begin
            insn_valid_o <= 1'b0;
            if (imem_req_o) begin
                // Hold request until the memory answers
                if (imem_ack_i) begin
                    imem_req_o   <= 1'b0;
                    insn_valid_o <= 1'b1;
                    pc           <= pc + 32'd4;
                    busy         <= 1'b1;
                end
            end else if (busy) begin
                if (retire_i) begin
                    busy <= 1'b0;
                end
            end else if (run_i && !halted_i) begin
                imem_req_o <= 1'b1;
            end
        end
    end

    // Word captured with the ack
    always_ff @(posedge clk) begin
        if (imem_req_o && imem_ack_i) begin
            insn_word_o <= imem_rdata_i;
        end
    end

endmodule : fetch_unit

`default_nettype wire

/* mem_core_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_core_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic imem_req_i,
    input wire logic dmem_cyc_i,
    input wire logic insn_valid_i,
    input wire logic dec_valid_i,
    input wire logic ex_valid_i,
    input wire logic wb_valid_i,
    input wire logic halted_i
);

    // Every strobe low after a reset edge
    strobes_low_in_reset: assert property (
        @(posedge clk) !rst_n |=> !(imem_req_i || dmem_cyc_i || insn_valid_i ||
                                    dec_valid_i || ex_valid_i || wb_valid_i || halted_i)
    ) else $error("strobe or halt active after a reset cycle");

    // One writeback per instruction
    wb_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_valid_i |=> !wb_valid_i
    ) else $error("wb_valid_o high for more than one cycle");

    // Nothing reaches the register file after ECALL
    no_wb_after_halt: assert property (
        @(posedge clk) disable iff (!rst_n) halted_i |-> !wb_valid_i
    ) else $error("wb_valid_o high while halted_o is set");

endmodule : mem_core_assert

bind mem_core_top mem_core_assert u_core_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_req_i   (imem_req),
    .dmem_cyc_i   (dmem_cyc),
    .insn_valid_i (insn_valid),
    .dec_valid_i  (dec_valid),
    .ex_valid_i   (ex_valid),
    .wb_valid_i   (wb_valid_o),
    .halted_i     (halted_o)
);

`default_nettype wire

/* mem_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_core_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          run_i,
    input  wire logic                          load_we_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  load_addr_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  load_data_i,
    output logic                               wb_valid_o,
    output logic [4:0]                         wb_rd_o,
    output logic [mem_map_pkg::XLEN-1:0]       wb_data_o,
    output logic                               halted_o
);

    // Instruction port
    logic                         imem_req, imem_ack;
    logic [mem_map_pkg::XLEN-1:0] imem_addr, imem_rdata;

    // Data port
    logic                         dmem_cyc, dmem_sel, dmem_wen, dmem_ack;
    logic [3:0]                   dmem_byte_en;
    logic [mem_map_pkg::XLEN-1:0] dmem_addr, dmem_wdata, dmem_rdata;

    // Fetch to decode
    logic                         insn_valid;
    logic [mem_map_pkg::XLEN-1:0] insn_word;

    // Decode to execute
    logic                         dec_valid;
    rv_isa_pkg::op_e              dec_op;
    logic [4:0]                   dec_rd, dec_rs1, dec_rs2;
    logic [mem_map_pkg::XLEN-1:0] dec_imm;
    logic [2:0]                   dec_width;

    // Register reads and execute to result
    logic [4:0]                   rs1_idx, rs2_idx;
    logic [mem_map_pkg::XLEN-1:0] rs1_data, rs2_data;
    logic                         ex_valid, retire;
    rv_isa_pkg::op_e              ex_op;
    logic [4:0]                   ex_rd;
    logic [mem_map_pkg::XLEN-1:0] ex_value;
    logic [1:0]                   ex_byte_off;
    logic [2:0]                   ex_width;

    dualport_mem u_mem (
        .clk, .rst_n,
        .imem_req_i(imem_req), .imem_addr_i(imem_addr),
        .imem_ack_o(imem_ack), .imem_rdata_o(imem_rdata),
        .dmem_cyc_i(dmem_cyc), .dmem_sel_i(dmem_sel), .dmem_wen_i(dmem_wen),
        .dmem_byte_en_i(dmem_byte_en), .dmem_addr_i(dmem_addr), .dmem_wdata_i(dmem_wdata),
        .dmem_ack_o(dmem_ack), .dmem_rdata_o(dmem_rdata)
    );

    fetch_unit u_fetch (
        .clk, .rst_n, .run_i, .retire_i(retire), .halted_i(halted_o),
        .imem_req_o(imem_req), .imem_addr_o(imem_addr),
        .imem_ack_i(imem_ack), .imem_rdata_i(imem_rdata),
        .insn_valid_o(insn_valid), .insn_word_o(insn_word)
    );

    decode_unit u_decode (
        .clk, .rst_n, .insn_valid_i(insn_valid), .insn_word_i(insn_word),
        .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_rd_o(dec_rd),
        .dec_rs1_o(dec_rs1), .dec_rs2_o(dec_rs2), .dec_imm_o(dec_imm),
        .dec_width_o(dec_width), .halted_o
    );

    execute_unit u_execute (
        .clk, .rst_n, .run_i, .load_we_i, .load_addr_i, .load_data_i,
        .dec_valid_i(dec_valid), .dec_op_i(dec_op), .dec_rd_i(dec_rd),
        .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2), .dec_imm_i(dec_imm),
        .dec_width_i(dec_width),
        .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .dmem_cyc_o(dmem_cyc), .dmem_sel_o(dmem_sel), .dmem_wen_o(dmem_wen),
        .dmem_byte_en_o(dmem_byte_en), .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_ack_i(dmem_ack), .dmem_rdata_i(dmem_rdata),
        .ex_valid_o(ex_valid), .ex_op_o(ex_op), .ex_rd_o(ex_rd), .ex_value_o(ex_value),
        .ex_byte_off_o(ex_byte_off), .ex_width_o(ex_width)
    );

    result_unit u_result (
        .clk, .rst_n,
        .ex_valid_i(ex_valid), .ex_op_i(ex_op), .ex_rd_i(ex_rd), .ex_value_i(ex_value),
        .ex_byte_off_i(ex_byte_off), .ex_width_i(ex_width),
        .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wb_valid_o, .wb_rd_o, .wb_data_o, .retire_o(retire)
    );

endmodule : mem_core_top

`default_nettype wire

/* mem_core_vectors.txt */
# P <byte address> <word>   written through the loader while run_i is low
# E <rd> <data>             next expected writeback, in program order
P 00000000 7ff00093  # addi x1, x0, 2047
P 00000004 7ff08113  # addi x2, x1, 2047
P 00000008 fff00193  # addi x3, x0, -1
P 0000000c 00218213  # addi x4, x3, 2 wraps to 1
P 00000010 00508013  # addi x0, x1, 5
P 00000014 00300293  # addi x5, x0, 3
P 00000018 20000313  # addi x6, x0, 0x200
P 0000001c a5a00393  # addi x7, x0, -1446
P 00000020 00732023  # sw   x7, 0(x6)
P 00000024 00032403  # lw   x8, 0(x6)
P 00000028 00430223  # sb   x4, 4(x6)
P 0000002c 005302a3  # sb   x5, 5(x6)
P 00000030 00230323  # sb   x2, 6(x6)
P 00000034 001303a3  # sb   x1, 7(x6)
P 00000038 00432483  # lw   x9, 4(x6)
P 0000003c 00734503  # lbu  x10, 7(x6)
P 00000040 00534583  # lbu  x11, 5(x6)
P 00000044 10032603  # lw   x12, 256(x6)
P 00000048 00000073  # ecall
P 00000300 cafef00d  # data word for the last lw
E 01 000007ff
E 02 00000ffe
E 03 ffffffff
E 04 00000001
E 00 00000000
E 05 00000003
E 06 00000200
E 07 fffffa5a
E 08 fffffa5a
E 09 fffe0301
E 0a 000000ff
E 0b 00000003
E 0c cafef00d

/* mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // Data word width
    localparam int XLEN = 32;

    // Shared instruction and data array, in words
    localparam int IDMEM_SIZE = 256;

    // Word index bits, log2 of IDMEM_SIZE
    localparam int MEM_ADDR_WIDTH = 8;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;

endpackage : mem_map_pkg

`default_nettype wire

/* result_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module result_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          ex_valid_i,
    input  wire rv_isa_pkg::op_e               ex_op_i,
    input  wire logic [4:0]                    ex_rd_i,
    input  wire logic [mem_map_pkg::XLEN-1:0]  ex_value_i,
    input  wire logic [1:0]                    ex_byte_off_i,
    input  wire logic [2:0]                    ex_width_i,
    input  wire logic [4:0]                    rs1_idx_i,
    input  wire logic [4:0]                    rs2_idx_i,
    output logic [mem_map_pkg::XLEN-1:0]       rs1_data_o,
    output logic [mem_map_pkg::XLEN-1:0]       rs2_data_o,
    output logic                               wb_valid_o,
    output logic [4:0]                         wb_rd_o,
    output logic [mem_map_pkg::XLEN-1:0]       wb_data_o,
    output logic                               retire_o
);

    logic [mem_map_pkg::XLEN-1:0] regs [32];
    logic [mem_map_pkg::XLEN-1:0] wr_data;
    logic [7:0]                   ld_byte;

    // Lane picked by the low address bits
    assign ld_byte = ex_value_i[{ex_byte_off_i, 3'b000} +: 8];

    // LBU zero-extends, LW and ADDI pass through
    assign wr_data = (ex_op_i == rv_isa_pkg::OP_LOAD && ex_width_i == rv_isa_pkg::F3_BYTEU)
                   ? {24'h000000, ld_byte} : ex_value_i;

    assign wb_valid_o = ex_valid_i &&
                        (ex_op_i == rv_isa_pkg::OP_ADDI || ex_op_i == rv_isa_pkg::OP_LOAD);
    assign wb_rd_o    = ex_rd_i;
    // x0 reports its architectural value
    assign wb_data_o  = (ex_rd_i == 5'd0) ? '0 : wr_data;

    // Stores, ECALL and unknown ops retire too
    assign retire_o = ex_valid_i;

    always_ff @(posedge clk) begin
        if (rst_n && wb_valid_o && ex_rd_i != 5'd0) begin
            regs[ex_rd_i] <= wr_data;
        end
    end

    assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs[rs2_idx_i];

endmodule : result_unit

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f tb.f --top-module tb_mem_core -o sim_mem_core

out=$(./obj_dir/sim_mem_core 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '** PASS **'

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ADDI shares its funct3 with the byte width code
    localparam logic [2:0] F3_ADDI  = 3'b000;

    // Access width codes in funct3
    localparam logic [2:0] F3_BYTE  = 3'b000;
    localparam logic [2:0] F3_WORD  = 3'b010;
    localparam logic [2:0] F3_BYTEU = 3'b100;

    // Register-immediate layout, also used for loads and ECALL
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    // Store layout, immediate split around rs2 and rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } stype_t;

    // One fetched word seen through both layouts
    typedef union packed {
        itype_t i;
        stype_t s;
    } insn_u;

    // Operation classes passed down the stages
    typedef enum logic [2:0] {
        OP_ADDI,
        OP_LOAD,
        OP_STORE,
        OP_HALT,
        OP_NONE
    } op_e;

endpackage : rv_isa_pkg

`default_nettype wire

/* tb.f */
mem_map_pkg.sv
rv_isa_pkg.sv
dualport_mem.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
mem_core_top.sv
mem_core_assert.sv
tb_mem_core.sv

/* tb_mem_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_core;

    // Cycles allowed for any single wait
    localparam int WAIT_LIMIT   = 100;
    // Cycles watched after halt for stray writebacks
    localparam int QUIET_CYCLES = 20;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        halted;

    // Program words and their byte addresses
    logic [31:0] prog_addr [$];
    logic [31:0] prog_word [$];
    // Expected writebacks in program order
    logic [31:0] exp_rd [$];
    logic [31:0] exp_data [$];

    // Every wb_valid_o pulse seen since reset
    int wb_count = 0;

    mem_core_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .run_i       (run),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .wb_valid_o  (wb_valid),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data),
        .halted_o    (halted)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // Writeback monitor, separate from the ordered checks
    always @(negedge clk) begin
        if (wb_valid === 1'b1) begin
            wb_count <= wb_count + 1;
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        assert (got === exp) else begin
            stop_on_error($sformatf("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                                    $time, name, got, exp));
        end
    endtask

    // P and E records
    // A # runs to the end of its line
    task automatic read_vectors();
        int          fd;
        int          c;
        int          n;
        logic [7:0]  ch;
        logic [31:0] f1;
        logic [31:0] f2;
        fd = $fopen("mem_core_vectors.txt", "r");
        assert (fd != 0) else begin
            stop_on_error("Cannot open mem_core_vectors.txt for reading");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            ch = c[7:0];
            if (ch == "#") begin
                // Skip to end of line
                while (c != -1 && ch != "\n") begin
                    c  = $fgetc(fd);
                    ch = c[7:0];
                end
            end else if (ch == "P" || ch == "E") begin
                n = $fscanf(fd, " %h %h", f1, f2);
                assert (n == 2) else begin
                    stop_on_error("Malformed record in mem_core_vectors.txt");
                end
                if (ch == "P") begin
                    prog_addr.push_back(f1);
                    prog_word.push_back(f2);
                end else begin
                    exp_rd.push_back(f1);
                    exp_data.push_back(f2);
                end
            end else begin
                assert (ch == " " || ch == "\t" || ch == "\r" || ch == "\n") else begin
                    stop_on_error("Unknown record type in mem_core_vectors.txt");
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        assert (prog_addr.size() > 0 && exp_rd.size() > 0) else begin
            stop_on_error("mem_core_vectors.txt holds no program or no expected writebacks");
        end
    endtask

    // Next wb_valid_o pulse as seen at the falling edge
    task automatic wait_writeback();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wb_valid && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (wb_valid) else begin
            stop_on_error($sformatf("Timeout at %0t ns, no writeback within %0d cycles",
                                    $time, WAIT_LIMIT));
        end
    endtask

    // No writeback may show up before the halt
    task automatic wait_halt();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!halted && cycles < WAIT_LIMIT) begin
            assert (!wb_valid) else begin
                stop_on_error("Writeback seen after the last expected one");
            end
            @(negedge clk);
            cycles++;
        end
        assert (halted) else begin
            stop_on_error("Timeout, halted_o did not rise after the program");
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        read_vectors();

        // Three rising edges in reset
        repeat (3) @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("wb_valid_o", 32'(wb_valid), 32'd0);
        check_value("halted_o", 32'(halted), 32'd0);

        // One word per cycle through the loader
        for (int i = 0; i < prog_addr.size(); i++) begin
            @(negedge clk);
            load_we   <= 1'b1;
            load_addr <= prog_addr[i];
            load_data <= prog_word[i];
        end
        @(negedge clk);
        load_we <= 1'b0;
        @(negedge clk);
        run <= 1'b1;

        // Writebacks in program order
        for (int i = 0; i < exp_rd.size(); i++) begin
            wait_writeback();
            check_value("wb_rd_o", 32'(wb_rd), exp_rd[i]);
            check_value("wb_data_o", wb_data, exp_data[i]);
        end

        wait_halt();

        // Machine stays quiet once halted
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            assert (!wb_valid) else begin
                stop_on_error("Writeback seen after halt");
            end
            assert (halted) else begin
                stop_on_error("halted_o dropped after ECALL");
            end
        end

        if (wb_count == exp_rd.size()) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_on_error($sformatf("Saw %0d writebacks, expected %0d",
                                    wb_count, exp_rd.size()));
        end
    end

endmodule : tb_mem_core

`default_nettype wire
